/* design/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define FIELD_COND(w) w[31:28]
`define FIELD_OP(w)   {w[27:20], w[7:4]}

// data processing excludes msr/mrs space (opcode 10xx with s clear) and multiplies
`define GROUP_B               12'b101?_????_????
`define GROUP_ALU \
	12'b0010_????_????, 12'b0011_1???_????, 12'b0011_0??1_????, \
	12'b0000_????_???0, 12'b0001_1???_???0, 12'b0001_0??1_???0, \
	12'b0000_????_0??1, 12'b0001_1???_0??1, 12'b0001_0??1_0??1
`define GROUP_LDST_SINGLE_IMM 12'b010?_????_????
`define GROUP_LDST_SINGLE_REG 12'b011?_????_???0

`define ALU_AND 4'b0000
`define ALU_EOR 4'b0001
`define ALU_SUB 4'b0010
`define ALU_RSB 4'b0011
`define ALU_ADD 4'b0100
`define ALU_ADC 4'b0101
`define ALU_SBC 4'b0110
`define ALU_RSC 4'b0111
`define ALU_TST 4'b1000
`define ALU_TEQ 4'b1001
`define ALU_CMP 4'b1010
`define ALU_CMN 4'b1011
`define ALU_ORR 4'b1100
`define ALU_MOV 4'b1101
`define ALU_BIC 4'b1110
`define ALU_MVN 4'b1111

`define R14 4'd14
`define R15 4'd15

`define DECODE_QUEUE_DEPTH 4

`endif

/* design/core_isa_pkg.sv */
package core_isa_pkg;

	typedef logic [31:0] word;
	typedef logic [29:0] ptr;
	typedef logic [3:0]  reg_num;

	typedef struct packed {
		logic [3:0]  cond;
		logic [2:0]  op;
		logic [3:0]  opcode;
		logic        s;
		reg_num      rn;
		reg_num      rd;
		logic [11:0] operand2;
	} insn_dp;

	typedef struct packed {
		logic [3:0]  cond;
		logic [2:0]  group;
		logic        link;
		logic [23:0] offset;
	} insn_br;

	typedef struct packed {
		logic [3:0]  cond;
		logic [2:0]  group;
		logic        p;
		logic        u;
		logic        b;
		logic        w;
		logic        l;
		reg_num      rn;
		reg_num      rd;
		logic [11:0] offset;
	} insn_ls;

	// one fetched word, read as whichever group the opcode bits select
	typedef union packed {
		insn_dp dp;
		insn_br br;
		insn_ls ls;
	} insn_word;

endpackage

/* design/core_uarch_pkg.sv */
package core_uarch_pkg;

	import core_isa_pkg::*;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	// asr is encoded as shr and ror both set
	typedef struct packed {
		logic        is_imm;
		logic [11:0] imm;
		reg_num      r;
		logic [4:0]  shift_imm;
		logic        shr;
		logic        ror;
		logic        shift_by_reg;
	} snd_decode;

	typedef struct packed {
		logic [3:0] op;
		reg_num     rd;
		reg_num     rn;
	} data_decode;

	typedef struct packed {
		logic enable;
		logic load;
		logic byte_access;
		logic writeback;
		logic pre;
		logic up;
	} ldst_decode;

	typedef struct packed {
		logic       execute;
		logic       undefined;
		logic       branch;
		ptr         branch_offset;
		logic       writeback;
		logic       update_flags;
		logic       uses_rn;
		snd_decode  snd;
		data_decode data;
		ldst_decode ldst;
	} decoded_insn;

endpackage

/* design/core_decode_if.sv */
`timescale 1ns/1ps

interface decode_if
	import core_uarch_pkg::*;
();

	decoded_insn dec;

	modport producer (
		output dec
	);

	modport consumer (
		input dec
	);

endinterface

/* design/core_decode_conds.sv */
`timescale 1ns/1ps

module core_decode_conds
	import core_uarch_pkg::*;
(
	input  logic [3:0] cond,
	input  psr_flags   flags,
	output logic       execute,
	output logic       undefined
);

	always_comb begin
		undefined = 0;

		case(cond)
			4'b0000: execute = flags.z; // eq
			4'b0001: execute = !flags.z; // ne
			4'b0010: execute = flags.c; // cs
			4'b0011: execute = !flags.c; // cc
			4'b0100: execute = flags.n; // mi
			4'b0101: execute = !flags.n; // pl
			4'b0110: execute = flags.v; // vs
			4'b0111: execute = !flags.v; // vc
			4'b1000: execute = flags.c && !flags.z; // hi
			4'b1001: execute = !flags.c || flags.z; // ls
			4'b1010: execute = flags.n == flags.v; // ge
			4'b1011: execute = flags.n != flags.v; // lt
			4'b1100: execute = !flags.z && flags.n == flags.v; // gt
			4'b1101: execute = flags.z || flags.n != flags.v; // le
			4'b1110: execute = 1; // al
			default: begin
				execute = 0;
				undefined = 1; // nv space is not decoded
			end
		endcase
	end

endmodule

/* design/core_decode_snd.sv */
`timescale 1ns/1ps

`include "core_defs.svh"

module core_decode_snd
	import core_isa_pkg::*;
	import core_uarch_pkg::*;
(
	input  insn_word  insn,
	input  logic      is_imm,
	input  logic      ror_if_imm,
	input  logic      shift_by_reg_if_reg,
	output snd_decode decode,
	output logic      undefined
);

	logic [1:0] shift_type;
	reg_num     rm;
	reg_num     rs;

	assign shift_type = insn.dp.operand2[6:5];
	assign rm = insn.dp.operand2[3:0];
	assign rs = insn.dp.operand2[11:8];

	always_comb begin
		decode.is_imm = is_imm;
		decode.imm = insn.dp.operand2; // rs is read from imm[11:8] for register shifts
		decode.r = rm;
		decode.shift_by_reg = !is_imm && shift_by_reg_if_reg;
		undefined = 0;

		if(is_imm) begin
			// the 8-bit immediate rotates right by twice the rotate field
			decode.shift_imm = ror_if_imm ? {insn.dp.operand2[11:8], 1'b0} : 5'd0;
			decode.shr = 0;
			decode.ror = ror_if_imm;
		end else begin
			decode.shift_imm = decode.shift_by_reg ? 5'd0 : insn.dp.operand2[11:7];
			decode.shr = shift_type == 2'b01 || shift_type == 2'b10; // lsr or asr
			decode.ror = shift_type[1]; // asr or ror
			undefined = decode.shift_by_reg && (rm == `R15 || rs == `R15);
		end
	end

endmodule

/* design/core_decode_data.sv */
`timescale 1ns/1ps

`include "core_defs.svh"

module core_decode_data
	import core_isa_pkg::*;
	import core_uarch_pkg::*;
(
	input  insn_word   insn,
	output data_decode decode,
	output logic       writeback,
	output logic       update_flags,
	output logic       snd_is_imm,
	output logic       snd_shift_by_reg_if_reg,
	output logic       uses_rn
);

	always_comb begin
		decode.op = insn.dp.opcode;
		decode.rd = insn.dp.rd;
		decode.rn = insn.dp.rn;

		snd_is_imm = insn.dp.op[0]; // bit 25 selects the rotated immediate
		snd_shift_by_reg_if_reg = insn.dp.operand2[4];

		writeback = 1;
		update_flags = insn.dp.s;
		uses_rn = 1;

		case(insn.dp.opcode)
			`ALU_TST, `ALU_TEQ, `ALU_CMP, `ALU_CMN: begin
				writeback = 0; // compares only set flags
				update_flags = 1;
			end
			`ALU_MOV, `ALU_MVN:
				uses_rn = 0;
			default: ;
		endcase
	end

endmodule

/* design/core_decode.sv */
`timescale 1ns/1ps

`include "core_defs.svh"

module core_decode
	import core_isa_pkg::*;
	import core_uarch_pkg::*;
(
	input  insn_word   insn,
	input  psr_flags   flags,
	decode_if.producer out
);

	logic cond_execute, cond_undefined;

	core_decode_conds conds (
		.cond(`FIELD_COND(insn)),
		.flags(flags),
		.execute(cond_execute),
		.undefined(cond_undefined)
	);

	logic       ldst_group;
	logic       snd_is_imm, snd_ror_if_imm, snd_shift_by_reg_if_reg, snd_undefined;
	snd_decode  snd;
	data_decode data;
	logic       data_writeback, data_update_flags, data_uses_rn;
	logic       data_is_imm, data_shift_by_reg_if_reg;
	decoded_insn dec;

	// a single load/store has bit 25 clear for an immediate offset
	assign ldst_group = insn.ls.group[2:1] == 2'b01;
	assign snd_is_imm = ldst_group ? !insn.ls.group[0] : data_is_imm;
	assign snd_ror_if_imm = !ldst_group;
	assign snd_shift_by_reg_if_reg = !ldst_group && data_shift_by_reg_if_reg;

	core_decode_snd snd_operand (
		.insn(insn),
		.is_imm(snd_is_imm),
		.ror_if_imm(snd_ror_if_imm),
		.shift_by_reg_if_reg(snd_shift_by_reg_if_reg),
		.decode(snd),
		.undefined(snd_undefined)
	);

	core_decode_data group_data (
		.insn(insn),
		.decode(data),
		.writeback(data_writeback),
		.update_flags(data_update_flags),
		.snd_is_imm(data_is_imm),
		.snd_shift_by_reg_if_reg(data_shift_by_reg_if_reg),
		.uses_rn(data_uses_rn)
	);

	always_comb begin
		dec = '0;
		dec.execute = cond_execute;
		dec.undefined = cond_undefined;
		dec.uses_rn = 1;
		dec.snd.is_imm = 1;

		priority casez(`FIELD_OP(insn))
			`GROUP_B: begin
				dec.branch = 1;
				dec.branch_offset = {{6{insn.br.offset[23]}}, insn.br.offset};
				if(insn.br.link) begin
					dec.data.op = `ALU_SUB; // lr gets pc minus 4
					dec.data.rd = `R14;
					dec.data.rn = `R15;
					dec.snd.imm = 12'd4;
					dec.writeback = 1;
				end
			end

			`GROUP_ALU: begin
				dec.uses_rn = data_uses_rn;
				dec.writeback = data_writeback;
				dec.update_flags = data_update_flags;
				dec.snd = snd;
				dec.data = data;
				dec.undefined = cond_undefined | snd_undefined;
			end

			`GROUP_LDST_SINGLE_IMM, `GROUP_LDST_SINGLE_REG: begin
				dec.snd = snd;
				dec.data.op = insn.ls.u ? `ALU_ADD : `ALU_SUB; // address is rn plus or minus offset
				dec.data.rd = insn.ls.rd;
				dec.data.rn = insn.ls.rn;
				dec.ldst.enable = 1;
				dec.ldst.load = insn.ls.l;
				dec.ldst.byte_access = insn.ls.b;
				dec.ldst.writeback = insn.ls.w;
				dec.ldst.pre = insn.ls.p;
				dec.ldst.up = insn.ls.u;
				dec.writeback = insn.ls.w | insn.ls.l;
				dec.undefined = cond_undefined | snd_undefined;
			end

			default: dec.undefined = 1;
		endcase

		if(dec.undefined) begin
			dec.execute = 0;
			dec.branch = 0;
			dec.writeback = 0;
			dec.update_flags = 0;
			dec.ldst.enable = 0;
		end
	end

	assign out.dec = dec;

endmodule

/* design/core_decode_flow.sv */
`timescale 1ns/1ps

`include "core_defs.svh"

module core_decode_flow
	import core_isa_pkg::*;
	import core_uarch_pkg::*;
#(
	parameter int OUT_CREDITS = 2
)
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid,
	input  word         in_insn,
	input  psr_flags    in_flags,
	input  logic        out_credit,
	output logic        in_credit,
	output insn_word    head_insn,
	output psr_flags    head_flags,
	decode_if.consumer  dec,
	output logic        out_valid,
	output decoded_insn out
);

	localparam int DEPTH = `DECODE_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

	word                 q_insn[DEPTH];
	psr_flags            q_flags[DEPTH];
	logic [PTR_W-1:0]    rd_ptr, wr_ptr;
	logic [PTR_W:0]      count;
	logic [CREDIT_W-1:0] credits;
	logic                pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return p == PTR_W'(DEPTH - 1) ? '0 : p + 1'b1;
	endfunction

	assign head_insn = q_insn[rd_ptr];
	assign head_flags = q_flags[rd_ptr];
	assign pop = count != 0 && credits != 0; // head leaves only when downstream has room

	always_ff @(posedge clk) begin
		if(in_valid) begin
			q_insn[wr_ptr] <= in_insn;
			q_flags[wr_ptr] <= in_flags;
		end
		if(pop)
			out <= dec.dec;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if(!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			credits <= CREDIT_W'(OUT_CREDITS);
			in_credit <= 0;
			out_valid <= 0;
		end else begin
			if(in_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if(pop)
				rd_ptr <= next_ptr(rd_ptr);

			case({in_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase

			case({pop, out_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: ;
			endcase

			in_credit <= pop; // freed slot goes back to fetch
			out_valid <= pop;
		end
	end

endmodule

/* design/core_decode_top.sv */
`timescale 1ns/1ps

module core_decode_top
	import core_isa_pkg::*;
	import core_uarch_pkg::*;
#(
	parameter int OUT_CREDITS = 2
)
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid,
	input  word         in_insn,
	input  psr_flags    in_flags,
	output logic        in_credit,
	output logic        out_valid,
	output logic        out_execute,
	output logic        out_undefined,
	output logic        out_branch,
	output ptr          out_branch_offset,
	output logic        out_writeback,
	output logic        out_update_flags,
	output logic        out_uses_rn,
	output logic [3:0]  out_alu_op,
	output reg_num      out_rd,
	output reg_num      out_rn,
	output logic        out_snd_is_imm,
	output logic [11:0] out_snd_imm,
	output reg_num      out_snd_r,
	output logic        out_ldst_enable,
	output logic        out_ldst_load,
	input  logic        out_credit
);

	decode_if    dec_bus ();
	insn_word    head_insn;
	psr_flags    head_flags;
	decoded_insn result;

	core_decode decode0 (
		.insn(head_insn),
		.flags(head_flags),
		.out(dec_bus)
	);

	core_decode_flow #(
		.OUT_CREDITS(OUT_CREDITS)
	) flow0 (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_insn(in_insn),
		.in_flags(in_flags),
		.out_credit(out_credit),
		.in_credit(in_credit),
		.head_insn(head_insn),
		.head_flags(head_flags),
		.dec(dec_bus),
		.out_valid(out_valid),
		.out(result)
	);

	assign out_execute = result.execute;
	assign out_undefined = result.undefined;
	assign out_branch = result.branch;
	assign out_branch_offset = result.branch_offset;
	assign out_writeback = result.writeback;
	assign out_update_flags = result.update_flags;
	assign out_uses_rn = result.uses_rn;
	assign out_alu_op = result.data.op;
	assign out_rd = result.data.rd;
	assign out_rn = result.data.rn;
	assign out_snd_is_imm = result.snd.is_imm;
	assign out_snd_imm = result.snd.imm;
	assign out_snd_r = result.snd.r;
	assign out_ldst_enable = result.ldst.enable;
	assign out_ldst_load = result.ldst.load;

endmodule

/* sim/core_decode_checker.sv */
`timescale 1ns/1ps

module core_decode_checker #(
	parameter int OUT_CREDITS = 2
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic in_credit,
	input logic out_credit,
	input logic out_valid,
	input logic out_execute,
	input logic out_undefined
);

	int received;
	int returned;
	int granted;
	int issued;

	always_ff @(posedge clk or negedge rst_n) begin
		if(!rst_n) begin
			received <= 0;
			returned <= 0;
			granted <= 0;
			issued <= 0;
		end else begin
			if(in_valid)
				received <= received + 1;
			if(in_credit)
				returned <= returned + 1;
			if(out_credit)
				granted <= granted + 1;
			if(out_valid)
				issued <= issued + 1;
		end
	end

	// each result spends one of the reset credits or one handed back on out_credit
	assert property (@(posedge clk) disable iff (!rst_n)
		issued + int'(out_valid) <= granted + OUT_CREDITS)
		else $error("out_valid raised while no downstream credit was held");

	assert property (@(posedge clk) disable iff (!rst_n) returned <= received)
		else $error("in_credit returned more credits than words received");

	assert property (@(posedge clk) disable iff (!rst_n) out_valid && out_undefined |-> !out_execute)
		else $error("undefined instruction marked for execution");

endmodule

bind core_decode_flow core_decode_checker #(.OUT_CREDITS(OUT_CREDITS)) checker0 (
	.clk(clk),
	.rst_n(rst_n),
	.in_valid(in_valid),
	.in_credit(in_credit),
	.out_credit(out_credit),
	.out_valid(out_valid),
	.out_execute(out.execute),
	.out_undefined(out.undefined)
);

/* sim/core_decode_tb.sv */
`timescale 1ns/1ps

`include "core_defs.svh"

module core_decode_tb
	import core_isa_pkg::*;
	import core_uarch_pkg::*;
;

	localparam int OUT_CREDITS = 2;
	localparam int M_COND = 0; // execute and undefined only
	localparam int M_DATA = 1;
	localparam int M_BRANCH = 2;
	localparam int M_LINK = 3;
	localparam int M_LDST = 4;

	typedef struct {
		word         insn;
		psr_flags    flags;
		int          mode;
		logic        execute, undefined, branch;
		ptr          offset;
		logic        writeback, update_flags, uses_rn;
		logic [3:0]  alu_op;
		reg_num      rd, rn;
		logic        snd_is_imm;
		logic [11:0] snd_imm;
		reg_num      snd_r;
		logic        ldst_enable, ldst_load;
	} entry_t;

	logic clk, rst_n, in_valid, in_credit, out_credit, out_valid;
	word in_insn;
	psr_flags in_flags;
	logic out_execute, out_undefined, out_branch, out_writeback, out_update_flags, out_uses_rn;
	logic out_snd_is_imm, out_ldst_enable, out_ldst_load;
	ptr out_branch_offset;
	logic [3:0] out_alu_op;
	reg_num out_rd, out_rn, out_snd_r;
	logic [11:0] out_snd_imm;

	entry_t table_q[$];
	int send_idx, recv_idx, up_credits, avail, owed, errors, failed_tests, cycles, limit;
	logic last_credit, entry_bad;
	logic [31:0] rng;

	core_decode_top #(.OUT_CREDITS(OUT_CREDITS)) dut0 (.*);

	initial begin
		clk = 0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	task automatic add_entry(input word insn, input psr_flags flags, input int mode,
		input logic execute, input logic undefined, input logic branch, input ptr offset,
		input logic writeback, input logic update_flags, input logic uses_rn,
		input logic [3:0] alu_op, input reg_num rd, input reg_num rn, input logic snd_is_imm,
		input logic [11:0] snd_imm, input reg_num snd_r, input logic ldst_enable,
		input logic ldst_load);
		entry_t e;
		e = '{insn, flags, mode, execute, undefined, branch, offset, writeback, update_flags,
			uses_rn, alu_op, rd, rn, snd_is_imm, snd_imm, snd_r, ldst_enable, ldst_load};
		table_q.push_back(e);
	endtask

	task automatic build_table();
		logic [15:0] exec_zc;
		logic [15:0] exec_nv;
		exec_zc = 16'b0110011010100101; // flags z and c set
		exec_nv = 16'b0101011001011010; // flags n and v set
		for(int c = 0; c < 16; c++)
			add_entry({c[3:0], 28'h0821003}, 4'b0110, M_COND, exec_zc[c], c == 15,
				0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		for(int c = 0; c < 15; c++)
			add_entry({c[3:0], 28'h0821003}, 4'b1001, M_COND, exec_nv[c], 0,
				0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_entry(32'hE0987109, 0, M_DATA, 1, 0, 0, 0, 1, 1, 1, `ALU_ADD, 7, 8, 0, 0, 9, 0, 0);
		add_entry(32'hE0421433, 0, M_DATA, 1, 0, 0, 0, 1, 0, 1, `ALU_SUB, 1, 2, 0, 0, 3, 0, 0);
		add_entry(32'hE35400FF, 0, M_DATA, 1, 0, 0, 0, 0, 1, 1, `ALU_CMP, 0, 4, 1, 12'h0ff, 0, 0, 0);
		add_entry(32'hE3A053A1, 0, M_DATA, 1, 0, 0, 0, 1, 0, 0, `ALU_MOV, 5, 0, 1, 12'h3a1, 0, 0, 0);
		add_entry(32'hE042143F, 0, M_COND, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_entry(32'hEA000010, 0, M_BRANCH, 1, 0, 1, 30'h10, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_entry(32'h0A000003, 0, M_BRANCH, 0, 0, 1, 30'h3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_entry(32'hEBFFFFFE, 0, M_LINK, 1, 0, 1, 30'h3ffffffe, 1, 0, 1, `ALU_SUB, `R14, `R15,
			1, 12'h004, 0, 0, 0);
		add_entry(32'hE5B53024, 0, M_LDST, 1, 0, 0, 0, 1, 0, 0, 0, 3, 5, 1, 12'h024, 0, 1, 1);
		add_entry(32'hE6062007, 0, M_LDST, 1, 0, 0, 0, 0, 0, 0, 0, 2, 6, 0, 0, 7, 1, 0);
		add_entry(32'hE5E21001, 0, M_LDST, 1, 0, 0, 0, 1, 0, 0, 0, 1, 2, 1, 12'h001, 0, 1, 0);
		add_entry(32'hEE000010, 0, M_COND, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_entry(32'hEF000000, 0, M_COND, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_entry(32'hE0010392, 0, M_COND, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	endtask

	task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			errors++;
			entry_bad = 1;
		end
	endtask

	task automatic check_entry(input entry_t e);
		check_field("execute", 32'(out_execute), 32'(e.execute));
		check_field("undefined", 32'(out_undefined), 32'(e.undefined));
		if(e.mode != M_COND) begin
			check_field("branch", 32'(out_branch), 32'(e.branch));
			check_field("writeback", 32'(out_writeback), 32'(e.writeback));
			check_field("ldst_enable", 32'(out_ldst_enable), 32'(e.ldst_enable));
		end
		if(e.mode == M_BRANCH || e.mode == M_LINK)
			check_field("branch_offset", 32'(out_branch_offset), 32'(e.offset));
		if(e.mode == M_DATA || e.mode == M_LINK)
			check_field("alu_op", 32'(out_alu_op), 32'(e.alu_op));
		if(e.mode == M_DATA || e.mode == M_LINK || e.mode == M_LDST) begin
			check_field("rd", 32'(out_rd), 32'(e.rd));
			check_field("rn", 32'(out_rn), 32'(e.rn));
			check_field("snd_is_imm", 32'(out_snd_is_imm), 32'(e.snd_is_imm));
			if(e.snd_is_imm)
				check_field("snd_imm", 32'(out_snd_imm), 32'(e.snd_imm));
			else
				check_field("snd_r", 32'(out_snd_r), 32'(e.snd_r));
		end
		if(e.mode == M_DATA) begin
			check_field("update_flags", 32'(out_update_flags), 32'(e.update_flags));
			check_field("uses_rn", 32'(out_uses_rn), 32'(e.uses_rn));
		end
		if(e.mode == M_LDST)
			check_field("ldst_load", 32'(out_ldst_load), 32'(e.ldst_load));
	endtask

	// fetch side, sends while it holds a credit
	always @(posedge clk) begin
		if(rst_n) begin
			if(in_credit)
				up_credits++;
			assert (up_credits <= `DECODE_QUEUE_DEPTH) else begin
				$display("upstream credits rose above the queue depth");
				errors++;
			end
			if(send_idx < table_q.size() && up_credits > 0) begin
				in_valid <= 1;
				in_insn <= table_q[send_idx].insn;
				in_flags <= table_q[send_idx].flags;
				send_idx++;
				up_credits--;
			end else begin
				in_valid <= 0;
			end
		end
	end

	// execute side, returns credits at random
	always @(posedge clk) begin
		if(rst_n) begin
			if(out_valid) begin
				assert (avail > 0) else begin
					$display("out_valid raised with no downstream credit granted");
					errors++;
				end
				avail--;
				owed++;
				assert (recv_idx < table_q.size()) else begin
					$display("output arrived with no table entry left to match");
					errors++;
				end
				if(recv_idx < table_q.size()) begin
					entry_bad = 0;
					check_entry(table_q[recv_idx]);
					if(entry_bad)
						failed_tests++;
					$display("test %0d insn %h: %s", recv_idx, table_q[recv_idx].insn,
						entry_bad ? "FAIL" : "ok");
				end
				recv_idx++;
			end
			avail += int'(last_credit); // a credit taken at one edge pays for out_valid two edges on
			last_credit = out_credit;
			rng = xorshift(rng);
			if(owed > 0 && rng[0]) begin
				out_credit <= 1;
				owed--;
			end else begin
				out_credit <= 0;
			end
		end
	end

	initial begin
		cycles = 0;
		while(cycles <= limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: %0d of %0d results arrived", recv_idx, table_q.size());
		$display("tests failed");
		$finish;
	end

	initial begin
		rst_n <= 0;
		in_valid <= 0;
		in_insn <= '0;
		in_flags <= '0;
		out_credit <= 0;
		send_idx = 0;
		recv_idx = 0;
		up_credits = `DECODE_QUEUE_DEPTH;
		avail = OUT_CREDITS;
		owed = 0;
		errors = 0;
		failed_tests = 0;
		last_credit = 0;
		rng = 32'hd20c_68c4;
		build_table();
		limit = table_q.size() * (OUT_CREDITS + 8) * 4 + 10;
		repeat(10) @(posedge clk);
		rst_n <= 1;
		wait(recv_idx == table_q.size());
		repeat(4) @(posedge clk); // catch any stray extra output
		$display("%0d tests, %0d failed, %0d errors", table_q.size(), failed_tests, errors);
		if(errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* core_decode_top.f */
+incdir+design
design/core_isa_pkg.sv
design/core_uarch_pkg.sv
design/core_decode_if.sv
design/core_decode_conds.sv
design/core_decode_snd.sv
design/core_decode_data.sv
design/core_decode.sv
design/core_decode_flow.sv
design/core_decode_top.sv
sim/core_decode_checker.sv
sim/core_decode_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= core_decode_tb
RTL_TOP ?= core_decode_top
FILELIST ?= core_decode_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) design/core_defs.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
